// File: sources.f
+incdir+logic
logic/rvPkg.sv
logic/instDecoder.sv
logic/intAlu.sv
logic/branchResolver.sv
logic/executeStage.sv
tests/executeStageTb.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f sources.f --top-module executeStageTb -o simExec
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/simExec > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tests/executeStageTb.sv
/*
 * executeStageTb
 * directed and random tests of the RV32I execute stage against an ISA model
 */
`timescale 1ns/1ps
`include "rvDefs_cfg.svh"

module executeStageTb;
    import rvPkg::*;

    localparam int TEST_CYCLES = 140; // all tests together, rounded up
    localparam int MARGIN      = 60;
    localparam int TIMEOUT_NS  = (TEST_CYCLES + MARGIN) * 4;

    logic        clk = 1'b0;
    logic        reset;
    logic        inValid;
    word_t       instWord;
    word_t       pc;
    word_t       rs1Data;
    word_t       rs2Data;
    logic        outValid;
    exResult_t   result;
    exResult_t   pendExp;    // prediction for the instruction in the output register
    logic        pending;
    int          errorCount;
    int unsigned seedVal;

    executeStage UUT (
        .clk(clk), .reset(reset), .inValid(inValid), .instWord(instWord), .pc(pc),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .outValid(outValid), .result(result)
    );

    always #2 clk = ~clk; // 4 ns period

    function automatic word_t randomPc();
        return $urandom & 32'hffff_fffc; // word aligned
    endfunction

    // instruction encoders, register fields random since data comes in directly
    function automatic word_t encR(input logic [6:0] f7, input funct3_t f3);
        return {f7, 10'($urandom), f3, 5'($urandom), `OPC_COMPUTE};
    endfunction

    function automatic word_t encI(input logic [11:0] imm, input funct3_t f3, input opcode_t op);
        return {imm, 5'($urandom), f3, 5'($urandom), op};
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input funct3_t f3);
        return {imm[11:5], 10'($urandom), f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t encB(input logic [12:0] off, input funct3_t f3);
        return {off[12], off[10:5], 10'($urandom), f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic word_t encJ(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'($urandom), `OPC_JAL};
    endfunction

    function automatic word_t aluModel(input funct3_t f3, input logic alt, input word_t a,
                                       input word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // expected result bundle from the RV32I rules
    function automatic exResult_t predict(input word_t inst, input word_t pcv, input word_t a,
                                          input word_t b);
        exResult_t  r;
        funct3_t    f3;
        logic [6:0] f7;
        word_t      immI;
        word_t      immS;
        word_t      immB;
        word_t      immU;
        word_t      immJ;
        word_t      target;
        logic       bad;
        logic       take;
        logic       shift;
        f3     = inst[14:12];
        f7     = inst[31:25];
        immI   = {{20{inst[31]}}, inst[31:20]};
        immS   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immB   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        immU   = {inst[31:12], 12'h000};
        immJ   = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        shift  = (f3 == 3'd1 || f3 == 3'd5);
        r      = '0;
        r.rdAddr = inst[11:7];
        r.nextPc = pcv + 32'd4;
        bad    = 1'b0;
        take   = 1'b0;
        target = '0;
        case (inst[6:0])
            `OPC_COMPUTE: begin
                bad       = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                r.wbData  = aluModel(f3, f7[5], a, b);
                r.rdWrite = 1'b1;
            end
            `OPC_ICOMPUTE: begin
                bad       = shift && !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5));
                r.wbData  = aluModel(f3, shift && f7[5], a, shift ? {27'b0, inst[24:20]} : immI);
                r.rdWrite = 1'b1;
            end
            `OPC_LOAD: begin
                bad       = (f3 == 3'd3 || f3 > 3'd5);
                r.memRead = 1'b1;
                r.rdWrite = 1'b1; // value itself comes back from memory
                r.memAddr = a + immI;
            end
            `OPC_STORE: begin
                bad         = (f3 > 3'd2);
                r.memWrite  = 1'b1;
                r.memAddr   = a + immS;
                r.storeData = b;
            end
            `OPC_BRANCH: begin
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    3'd6:    take = (a < b);
                    3'd7:    take = (a >= b);
                    default: bad = 1'b1;
                endcase
                target = pcv + immB;
            end
            `OPC_JAL: begin
                take      = 1'b1;
                target    = pcv + immJ;
                r.wbData  = pcv + 32'd4; // link
                r.rdWrite = 1'b1;
            end
            `OPC_JALR: begin
                take      = 1'b1;
                target    = a + immI;
                r.wbData  = pcv + 32'd4;
                r.rdWrite = 1'b1;
            end
            `OPC_LUI: begin
                r.wbData  = immU;
                r.rdWrite = 1'b1;
            end
            `OPC_AUIPC: begin
                r.wbData  = pcv + immU;
                r.rdWrite = 1'b1;
            end
            default: bad = 1'b1;
        endcase
        r.memSize = f3[1:0]; // byte, half, word follow funct3
        if (take) begin
            r.nextPc = target;
            bad      = bad || (target[1:0] != 2'b00);
        end
        if (r.memRead || r.memWrite)
            bad = bad || (f3[1:0] == 2'd1 && r.memAddr[0]) ||
                  (f3[1:0] == 2'd2 && r.memAddr[1:0] != 2'b00);
        r.halt = bad;
        if (bad) begin
            r.rdWrite  = 1'b0; // no side effects once halted
            r.memRead  = 1'b0;
            r.memWrite = 1'b0;
        end
        return r;
    endfunction

    task automatic failRun(input string what);
        errorCount++;
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkField(input string name, input word_t expVal, input word_t actVal);
        assert (actVal === expVal)
        else failRun($sformatf("Fail at %0t ns: %s expected %h actual %h",
                               $time, name, expVal, actVal));
    endtask

    task automatic checkResult(input exResult_t e);
        checkField("outValid", 32'd1, 32'(outValid));
        checkField("halt", 32'(e.halt), 32'(result.halt));
        checkField("rdWrite", 32'(e.rdWrite), 32'(result.rdWrite));
        checkField("memRead", 32'(e.memRead), 32'(result.memRead));
        checkField("memWrite", 32'(e.memWrite), 32'(result.memWrite));
        if (!e.halt)
            checkField("nextPc", e.nextPc, result.nextPc);
        if (e.rdWrite) begin
            checkField("wbData", e.wbData, result.wbData);
            checkField("rdAddr", 32'(e.rdAddr), 32'(result.rdAddr));
        end
        if (e.memRead || e.memWrite) begin
            checkField("memAddr", e.memAddr, result.memAddr);
            checkField("memSize", 32'(e.memSize), 32'(result.memSize));
        end
        if (e.memWrite)
            checkField("storeData", e.storeData, result.storeData);
    endtask

    // called 1 ns after the edge, the register holds the previous instruction
    task automatic sampleCheck();
        if (pending)
            checkResult(pendExp);
        else
            checkField("outValid", 32'd0, 32'(outValid));
    endtask

    task automatic issue(input word_t inst, input word_t pcv, input word_t a, input word_t b);
        @(posedge clk);
        #1;
        sampleCheck();
        inValid  = 1'b1;
        instWord = inst;
        pc       = pcv;
        rs1Data  = a;
        rs2Data  = b;
        pendExp  = predict(inst, pcv, a, b);
        pending  = 1'b1;
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        sampleCheck();
        inValid = 1'b0;
        pending = 1'b0;
    endtask

    task automatic resetTest();
        checkField("outValid", 32'd0, 32'(outValid));
        checkField("rdWrite", 32'd0, 32'(result.rdWrite));
        checkField("memRead", 32'd0, 32'(result.memRead));
        checkField("memWrite", 32'd0, 32'(result.memWrite));
        checkField("halt", 32'd0, 32'(result.halt));
        idle();
        idle(); // idle input gives idle output
    endtask

    task automatic aluTest();
        funct3_t    f3;
        logic       isReg;
        logic       alt;
        logic [6:0] f7;
        for (int i = 0; i < 40; i++) begin
            f3    = 3'($urandom_range(7, 0));
            isReg = 1'($urandom_range(1, 0));
            alt   = (f3 == 3'd5 || (isReg && f3 == 3'd0)) && 1'($urandom_range(1, 0));
            f7    = alt ? 7'h20 : 7'h00; // sub or sra when set
            if (isReg)
                issue(encR(f7, f3), randomPc(), $urandom, $urandom);
            else if (f3 == 3'd1 || f3 == 3'd5)
                issue(encI({f7, 5'($urandom)}, f3, `OPC_ICOMPUTE), randomPc(), $urandom, 0);
            else
                issue(encI(12'($urandom), f3, `OPC_ICOMPUTE), randomPc(), $urandom, $urandom);
        end
        idle();
    endtask

    task automatic branchTest();
        funct3_t     conds[6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [12:0] off;
        word_t       a;
        word_t       pcv;
        foreach (conds[k]) begin
            off = 13'($urandom) & 13'h1ffc;
            a   = $urandom;
            pcv = randomPc();
            issue(encB(off, conds[k]), pcv, a, a);         // equal
            issue(encB(off, conds[k]), pcv, a, ~a);        // sign differs
            issue(encB(off, conds[k]), pcv, a, a + 32'd1); // unequal, near
        end
        pcv = randomPc();
        issue(encB(13'h0006, 3'd0), pcv, 32'd5, 32'd5);   // taken to pc+6, halts
        issue(encJ(21'($urandom) & 21'h1ffffc), pcv, 0, 0);
        issue(encJ(21'h000002), pcv, 0, 0);               // misaligned jal target
        issue(encI(12'($urandom) & 12'hffc, 3'd0, `OPC_JALR), pcv, randomPc(), 0);
        issue(encI(12'h010, 3'd0, `OPC_JALR), pcv, 32'h0000_1001, 0);
        idle();
    endtask

    task automatic upperTest();
        for (int i = 0; i < 6; i++) begin
            issue({20'($urandom), 5'($urandom), `OPC_LUI}, randomPc(), $urandom, $urandom);
            issue({20'($urandom), 5'($urandom), `OPC_AUIPC}, randomPc(), $urandom, $urandom);
        end
        idle();
    endtask

    task automatic memTest();
        word_t       base;
        logic [11:0] imm;
        for (int f = 0; f < 6; f++) begin
            for (int off = 0; off < 4; off++) begin
                base = $urandom & 32'hffff_fff0;
                imm  = (12'($urandom) & 12'hff0) | 12'(off); // low bits set the alignment
                issue(encI(imm, 3'(f), `OPC_LOAD), randomPc(), base, $urandom);
                if (f < 3)
                    issue(encS(imm, 3'(f)), randomPc(), base, $urandom);
            end
        end
        idle();
    endtask

    task automatic illegalTest();
        issue({25'($urandom), 7'b1111111}, randomPc(), $urandom, $urandom); // unknown opcode
        issue({25'($urandom), 7'b0001111}, randomPc(), $urandom, $urandom); // fence, unsupported
        issue(encR(7'b0000001, 3'd0), randomPc(), $urandom, $urandom);      // mul
        issue(encR(7'b0100000, 3'd1), randomPc(), $urandom, $urandom);
        issue(encI({7'h20, 5'd3}, 3'd1, `OPC_ICOMPUTE), randomPc(), $urandom, 0);
        issue(encS(12'h010, 3'd3), randomPc(), 32'h100, $urandom);         // no 64-bit store
        issue(encB(13'h0010, 3'd2), randomPc(), $urandom, $urandom);
        idle();
    endtask

    initial begin
        #(TIMEOUT_NS);
        failRun("timeout, the tests did not finish in time");
    end

    initial begin
        seedVal    = $urandom(44341);
        reset      = 1'b1;
        inValid    = 1'b0;
        instWord   = '0;
        pc         = '0;
        rs1Data    = '0;
        rs2Data    = '0;
        pending    = 1'b0;
        errorCount = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        resetTest();
        aluTest();
        branchTest();
        upperTest();
        memTest();
        illegalTest();
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: logic/executeStage.sv
/*
 * executeStage
 * registered RV32I execute stage, one instruction in and one result out per cycle
 */
`timescale 1ns/1ps
`include "rvDefs_cfg.svh"

module executeStage (
    input  logic             clk,
    input  logic             reset,
    input  logic             inValid,
    input  rvPkg::word_t     instWord,
    input  rvPkg::word_t     pc,
    input  rvPkg::word_t     rs1Data,
    input  rvPkg::word_t     rs2Data,
    output logic             outValid,
    output rvPkg::exResult_t result
);
    import rvPkg::*;

    ctrl_t     ctrl;
    word_t     imm;
    regIdx_t   rdAddr;
    word_t     aluA, aluB, aluOut;
    logic      aluIllegal;
    word_t     nextPc;
    logic      targetMisaligned;
    logic      memMisaligned;
    logic      halt;
    word_t     pcPlus4;
    word_t     wbData;
    exResult_t resNext;

    instDecoder decoder (.instWord(instWord), .ctrl(ctrl), .imm(imm), .rdAddr(rdAddr));

    assign aluA = ctrl.aluSrcPc ? pc : rs1Data;
    assign aluB = ctrl.aluSrcImm ? imm : rs2Data;

    intAlu alu (
        .opcode(instWord[6:0]), .funct3(instWord[14:12]), .funct7(instWord[31:25]),
        .opA(aluA), .opB(aluB), .aluOut(aluOut), .aluIllegal(aluIllegal)
    );

    branchResolver branch (
        .ctrl(ctrl), .funct3(instWord[14:12]), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .aluOut(aluOut), .pc(pc), .nextPc(nextPc), .targetMisaligned(targetMisaligned)
    );

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.wbSel)
            `WB_ALU: wbData = aluOut;
            `WB_PC4: wbData = pcPlus4; // jal, jalr link
            `WB_IMM: wbData = imm;     // lui
            default: wbData = '0;      // loads, stores, branches
        endcase
    end

    // byte access never faults
    assign memMisaligned = (ctrl.memRead || ctrl.memWrite) &&
                           ((ctrl.memSize == `SIZE_HALF && aluOut[0]) ||
                            (ctrl.memSize == `SIZE_WORD && aluOut[1:0] != 2'b00));

    assign halt = ctrl.illegal || aluIllegal || memMisaligned || targetMisaligned;

    always_comb begin
        resNext.wbData    = wbData;
        resNext.rdAddr    = rdAddr;
        resNext.rdWrite   = inValid && ctrl.rdWrite && !halt; // halted op has no side effect
        resNext.nextPc    = nextPc;
        resNext.memRead   = inValid && ctrl.memRead && !halt;
        resNext.memWrite  = inValid && ctrl.memWrite && !halt;
        resNext.memAddr   = aluOut;
        resNext.memSize   = ctrl.memSize;
        resNext.storeData = rs2Data;
        resNext.halt      = inValid && halt; // idle cycles never flag
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid         <= 1'b0;
            result.rdWrite   <= 1'b0;
            result.memRead   <= 1'b0;
            result.memWrite  <= 1'b0;
            result.halt      <= 1'b0;
        end else begin
            outValid <= inValid; // one cycle latency, no back-pressure
            result   <= resNext;
        end
    end

    // a faulting store must not reach memory
    assert property (@(posedge clk) disable iff (reset) result.halt |-> !result.memWrite);

    // fall-through target is only aligned for an aligned pc
    assert property (@(posedge clk) disable iff (reset) inValid |-> pc[1:0] == 2'b00);

endmodule

// File: logic/branchResolver.sv
/*
 * branchResolver
 * branch condition, next pc choice and taken-target alignment check
 */
`timescale 1ns/1ps
`include "rvDefs_cfg.svh"

module branchResolver (
    input  rvPkg::ctrl_t   ctrl,
    input  rvPkg::funct3_t funct3,
    input  rvPkg::word_t   rs1Data,
    input  rvPkg::word_t   rs2Data,
    input  rvPkg::word_t   aluOut,
    input  rvPkg::word_t   pc,
    output rvPkg::word_t   nextPc,
    output logic           targetMisaligned
);
    import rvPkg::*;

    logic  cond;   // compare result for the branch funct3
    logic  taken;
    word_t pcPlus4;

    always_comb begin
        case (funct3)
            `F3_BEQ:  cond = (rs1Data == rs2Data);
            `F3_BNE:  cond = (rs1Data != rs2Data);
            `F3_BLT:  cond = ($signed(rs1Data) < $signed(rs2Data));
            `F3_BGE:  cond = ($signed(rs1Data) >= $signed(rs2Data));
            `F3_BLTU: cond = (rs1Data < rs2Data);
            `F3_BGEU: cond = (rs1Data >= rs2Data);
            default:  cond = 1'b0; // decoder flags these as illegal
        endcase
    end

    assign taken   = ctrl.isJump || (ctrl.isBranch && cond);
    assign pcPlus4 = pc + 32'd4;
    assign nextPc  = taken ? aluOut : pcPlus4; // alu holds pc+imm or rs1+imm

    // only a taken target can fault, fall-through is always aligned
    assign targetMisaligned = taken && (aluOut[1:0] != 2'b00);

endmodule

// File: logic/intAlu.sv
/*
 * intAlu
 * RV32I integer ALU with funct7 legality, plain adder for non-compute ops
 */
`timescale 1ns/1ps
`include "rvDefs_cfg.svh"

module intAlu (
    input  rvPkg::opcode_t opcode,
    input  rvPkg::funct3_t funct3,
    input  logic [6:0]     funct7,
    input  rvPkg::word_t   opA,
    input  rvPkg::word_t   opB,
    output rvPkg::word_t   aluOut,
    output logic           aluIllegal
);
    import rvPkg::*;

    logic  isReg;      // r-type
    logic  isCompute;  // r-type or i-type compute
    logic  f7Checked;  // funct7 field carries meaning
    logic  altAllowed; // 0100000 is a valid funct7 here
    logic  useAlt;
    logic  [4:0] shamt;
    word_t sum;

    assign isReg     = (opcode == `OPC_COMPUTE);
    assign isCompute = isReg || (opcode == `OPC_ICOMPUTE);
    assign shamt     = opB[4:0];

    // for i-type only the shift forms keep funct7 out of the immediate
    assign f7Checked  = isReg || funct3 == `F3_SLL || funct3 == `F3_SR;
    assign altAllowed = (funct3 == `F3_SR) || (isReg && funct3 == `F3_ADD);
    assign aluIllegal = isCompute && f7Checked &&
                        !(funct7 == `F7_BASE || (altAllowed && funct7 == `F7_ALT));
    assign useAlt     = (funct7 == `F7_ALT);

    assign sum = (isReg && funct3 == `F3_ADD && useAlt) ? opA - opB : opA + opB; // sub

    always_comb begin
        aluOut = sum; // address and target math for everything else
        if (isCompute) begin
            case (funct3)
                `F3_ADD:  aluOut = sum;
                `F3_SLL:  aluOut = opA << shamt;
                `F3_SLT:  aluOut = {31'b0, $signed(opA) < $signed(opB)};
                `F3_SLTU: aluOut = {31'b0, opA < opB};
                `F3_XOR:  aluOut = opA ^ opB;
                `F3_SR:   aluOut = useAlt ? word_t'($signed(opA) >>> shamt) // sra
                                          : opA >> shamt;                   // srl
                `F3_OR:   aluOut = opA | opB;
                default:  aluOut = opA & opB; // and
            endcase
        end
    end

endmodule

// File: logic/instDecoder.sv
/*
 * instDecoder
 * opcode to control bundle, immediate generation, illegal encoding check
 */
`timescale 1ns/1ps
`include "rvDefs_cfg.svh"

module instDecoder (
    input  rvPkg::word_t   instWord,
    output rvPkg::ctrl_t   ctrl,
    output rvPkg::word_t   imm,
    output rvPkg::regIdx_t rdAddr
);
    import rvPkg::*;

    opcode_t opcode;
    funct3_t funct3;

    assign opcode = instWord[6:0];
    assign funct3 = instWord[14:12];
    assign rdAddr = instWord[11:7]; // rd sits in the same place for every format

    always_comb begin
        ctrl = '0;                     // nothing enabled by default
        ctrl.immSel  = `IMM_R;
        ctrl.wbSel   = `WB_NONE;
        ctrl.memSize = `SIZE_BYTE;
        case (opcode)
            `OPC_COMPUTE: begin
                ctrl.rdWrite = 1'b1;
                ctrl.wbSel   = `WB_ALU;
            end
            `OPC_ICOMPUTE: begin
                if (funct3 == `F3_SLL || funct3 == `F3_SR)
                    ctrl.immSel = `IMM_SI; // shamt only
                else
                    ctrl.immSel = `IMM_I;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rdWrite   = 1'b1;
                ctrl.wbSel     = `WB_ALU;
            end
            `OPC_LOAD: begin
                ctrl.immSel    = `IMM_I;
                ctrl.aluSrcImm = 1'b1;  // rs1 + offset
                ctrl.rdWrite   = 1'b1;  // data comes back from memory later
                ctrl.memRead   = 1'b1;
                case (funct3)
                    3'b000, 3'b100: ctrl.memSize = `SIZE_BYTE; // lb, lbu
                    3'b001, 3'b101: ctrl.memSize = `SIZE_HALF; // lh, lhu
                    3'b010:         ctrl.memSize = `SIZE_WORD; // lw
                    default:        ctrl.illegal = 1'b1;
                endcase
            end
            `OPC_STORE: begin
                ctrl.immSel    = `IMM_S;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                case (funct3)
                    3'b000:  ctrl.memSize = `SIZE_BYTE; // sb
                    3'b001:  ctrl.memSize = `SIZE_HALF; // sh
                    3'b010:  ctrl.memSize = `SIZE_WORD; // sw
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            `OPC_BRANCH: begin
                ctrl.immSel    = `IMM_B;
                ctrl.aluSrcPc  = 1'b1;  // alu forms pc + offset
                ctrl.aluSrcImm = 1'b1;
                ctrl.isBranch  = 1'b1;
                ctrl.illegal   = (funct3 == 3'b010) || (funct3 == 3'b011); // no such compare
            end
            `OPC_JAL: begin
                ctrl.immSel    = `IMM_J;
                ctrl.aluSrcPc  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.isJump    = 1'b1;
                ctrl.rdWrite   = 1'b1;
                ctrl.wbSel     = `WB_PC4; // link
            end
            `OPC_JALR: begin
                ctrl.immSel    = `IMM_I;
                ctrl.aluSrcImm = 1'b1;  // rs1 + offset
                ctrl.isJump    = 1'b1;
                ctrl.rdWrite   = 1'b1;
                ctrl.wbSel     = `WB_PC4;
            end
            `OPC_LUI: begin
                ctrl.immSel  = `IMM_U;
                ctrl.rdWrite = 1'b1;
                ctrl.wbSel   = `WB_IMM; // alu result unused
            end
            `OPC_AUIPC: begin
                ctrl.immSel    = `IMM_U;
                ctrl.aluSrcPc  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.rdWrite   = 1'b1;
                ctrl.wbSel     = `WB_ALU;
            end
            default: ctrl.illegal = 1'b1; // unknown opcode
        endcase
    end

    always_comb begin
        case (ctrl.immSel)
            `IMM_I:  imm = {{20{instWord[31]}}, instWord[31:20]};
            `IMM_S:  imm = {{20{instWord[31]}}, instWord[31:25], instWord[11:7]};
            `IMM_B:  imm = {{20{instWord[31]}}, instWord[7], instWord[30:25],
                            instWord[11:8], 1'b0};
            `IMM_U:  imm = {instWord[31:12], 12'b0};
            `IMM_J:  imm = {{12{instWord[31]}}, instWord[19:12], instWord[20],
                            instWord[30:21], 1'b0};
            `IMM_SI: imm = {27'b0, instWord[24:20]}; // shift amount
            default: imm = '0;                       // r-type
        endcase
    end

    // a memory op is either a read or a write, never both
    assert property (@(ctrl) !(ctrl.memRead && ctrl.memWrite));

endmodule

// File: logic/rvPkg.sv
/*
 * rvPkg
 * shared field types and bundles of the RV32I execute stage
 */
`include "rvDefs_cfg.svh"

package rvPkg;

    typedef logic [`XLEN-1:0] word_t;   // data or address word
    typedef logic [4:0]       regIdx_t; // register index
    typedef logic [6:0]       opcode_t;
    typedef logic [2:0]       funct3_t;
    typedef logic [2:0]       immSel_t; // IMM_* codes
    typedef logic [1:0]       wbSel_t;  // WB_* codes
    typedef logic [1:0]       memSize_t; // SIZE_* codes

    // decoded control, one per instruction
    typedef struct packed {
        immSel_t  immSel;
        wbSel_t   wbSel;
        logic     aluSrcPc;  // operand a is pc, else rs1
        logic     aluSrcImm; // operand b is imm, else rs2
        logic     isBranch;  // conditional branch
        logic     isJump;    // jal or jalr, always taken
        logic     rdWrite;
        logic     memRead;
        logic     memWrite;
        memSize_t memSize;
        logic     illegal;   // bad opcode or funct3
    } ctrl_t;

    // registered stage output
    typedef struct packed {
        word_t    wbData;
        regIdx_t  rdAddr;
        logic     rdWrite;
        word_t    nextPc;
        logic     memRead;
        logic     memWrite;
        word_t    memAddr;
        memSize_t memSize;
        word_t    storeData;
        logic     halt;
    } exResult_t;

endpackage

// File: logic/rvDefs_cfg.svh
/*
 * RV32I execute stage configuration
 * opcode, funct, immediate format, write-back and access size codes
 */
`ifndef RV_DEFS_CFG_SVH
`define RV_DEFS_CFG_SVH

`define XLEN 32

`define OPC_COMPUTE  7'b0110011 // register-register ops
`define OPC_ICOMPUTE 7'b0010011 // register-immediate ops
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111

`define F7_BASE 7'b0000000 // add, srl and the rest
`define F7_ALT  7'b0100000 // sub, sra

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SR   3'b101 // srl or sra, picked by funct7
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define IMM_R  3'b000 // no immediate
`define IMM_I  3'b001
`define IMM_S  3'b010
`define IMM_B  3'b011
`define IMM_U  3'b100
`define IMM_J  3'b101
`define IMM_SI 3'b110 // shift amount, zero extended

`define WB_ALU  2'b00
`define WB_NONE 2'b01 // loads, stores, branches write back zero
`define WB_PC4  2'b10 // link value
`define WB_IMM  2'b11

`define SIZE_BYTE 2'b00
`define SIZE_HALF 2'b01
`define SIZE_WORD 2'b10

`endif
